// ==== include/dcache_macros.svh ====
// Geometry of the direct-mapped cache; DC_TAG_BITS must equal ADDR - INDEX - OFFSET bits
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// ============================================================
// Address split
// ============================================================
`define DC_ADDR_BITS    32
`define DC_INDEX_BITS   6
`define DC_OFFSET_BITS  4
`define DC_TAG_BITS     22

// Field positions inside a byte address
`define DC_WORD_LSB     2
`define DC_INDEX_LSB    (`DC_OFFSET_BITS)
`define DC_TAG_LSB      (`DC_OFFSET_BITS + `DC_INDEX_BITS)

// ============================================================
// Line and bus sizes
// ============================================================
`define DC_LINES        64
`define DC_LINE_WORDS   4
`define DC_WB_DATA_BITS 32
`define DC_WB_SEL_BITS  4
`define DC_LINE_BITS    (`DC_LINE_WORDS * `DC_WB_DATA_BITS)
`define DC_BYTE_EN_BITS (`DC_LINE_WORDS * `DC_WB_SEL_BITS)

// Statistics counters
`define DC_STAT_BITS    32

`endif

// ==== verilog/dcache_pkg.sv ====
// Cache types; access_size_t value 3 is unused and treated as a word access
`include "dcache_macros.svh"

package dcache_pkg;

  // ============================================================
  // Core access size
  // ============================================================
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_t;

  // ============================================================
  // Controller states
  // ============================================================
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_LOOKUP     = 3'd1,
    ST_READ_FILL  = 3'd2,
    ST_FILL_WRITE = 3'd3,
    ST_RESPOND    = 3'd4,
    ST_STORE      = 3'd5
  } dc_state_t;

  // Tag RAM entry
  typedef struct packed {
    logic [`DC_TAG_BITS-1:0] tag;
  } tag_entry_t;

  // Word 0 sits in the low 32 bits
  typedef logic [`DC_LINE_WORDS-1:0][`DC_WB_DATA_BITS-1:0] line_t;

endpackage

// ==== verilog/dcache_array_if.sv ====
// Controller to tag/data store link; hit and line_rdata are valid one cycle after lookup
`include "dcache_macros.svh"

interface dcache_array_if;

  logic [`DC_INDEX_BITS-1:0]   index;
  logic [`DC_TAG_BITS-1:0]     req_tag;
  logic                        lookup;
  logic                        tag_write;
  logic                        line_write;
  dcache_pkg::line_t           line_wdata;
  logic [`DC_BYTE_EN_BITS-1:0] byte_en;
  logic                        fill;
  logic                        hit;
  dcache_pkg::line_t           line_rdata;

  modport ctrl (
    output index, req_tag, lookup, tag_write, line_write, line_wdata, byte_en, fill,
    input  hit, line_rdata
  );

  modport tag (
    input  index, req_tag, lookup, tag_write, fill,
    output hit
  );

  modport data (
    input  index, lookup, line_write, line_wdata, byte_en, fill,
    output line_rdata
  );

endinterface

// ==== verilog/dcache_sram.sv ====
// Single-port RAM, one entry per line; read data holds until the next read, no reset
`include "dcache_macros.svh"

module dcache_sram #(
  parameter type entry_t = logic [`DC_WB_DATA_BITS-1:0]
) (
  input  logic                     clk,
  input  logic                     en,
  input  logic                     we,
  input  logic [`DC_INDEX_BITS-1:0] addr,
  input  entry_t                   wdata,
  output entry_t                   rdata
);

  entry_t mem [`DC_LINES];

  // Write wins over read, rdata keeps its last value on a write
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

  // Address comes from the controller and must be resolved on any access
  addr_known_a : assert property (@(posedge clk) en |-> !$isunknown(addr))
    else $error("dcache_sram accessed with unknown address");

endmodule

// ==== verilog/dcache_tag_store.sv ====
// Tag RAM plus valid flops; hit is only meaningful in the cycle after a lookup
`include "dcache_macros.svh"

module dcache_tag_store (
  input  logic         clk,
  input  logic         rstn,
  dcache_array_if.tag  arr
);

  logic [`DC_LINES-1:0]      valid;
  logic [`DC_INDEX_BITS-1:0] index_q;
  logic [`DC_TAG_BITS-1:0]   tag_q;
  dcache_pkg::tag_entry_t    wr_entry;
  dcache_pkg::tag_entry_t    rd_entry;

  assign wr_entry.tag = arr.req_tag;

  dcache_sram #(
    .entry_t(dcache_pkg::tag_entry_t)
  ) tag_ram (
    .clk  (clk),
    .en   (arr.lookup | arr.tag_write),
    .we   (arr.tag_write),
    .addr (arr.index),
    .wdata(wr_entry),
    .rdata(rd_entry)
  );

  // ============================================================
  // Valid bits
  // ============================================================
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else if (arr.tag_write && arr.fill) begin
      valid[arr.index] <= 1'b1;
    end
  end

  // Request captured alongside the RAM read
  always_ff @(posedge clk) begin
    if (arr.lookup) begin
      index_q <= arr.index;
      tag_q   <= arr.req_tag;
    end
  end

  assign arr.hit = valid[index_q] && (rd_entry.tag == tag_q);

  // A fill writes the RAM, so it cannot share the cycle with a read
  fill_no_lookup_a : assert property (
    @(posedge clk) disable iff (!rstn) !(arr.fill && arr.lookup)
  ) else $error("fill and lookup asserted together");

endmodule

// ==== verilog/dcache_data_store.sv ====
// Line RAM; a store merge relies on line_rdata from the preceding lookup of the same line
`include "dcache_macros.svh"

module dcache_data_store (
  input  logic          clk,
  input  logic          rstn,
  dcache_array_if.data  arr
);

  logic [`DC_LINE_BITS-1:0] old_bits;
  logic [`DC_LINE_BITS-1:0] new_bits;
  logic [`DC_LINE_BITS-1:0] merged_bits;
  dcache_pkg::line_t        wr_line;
  logic                     rd_ok;

  assign old_bits = arr.line_rdata;
  assign new_bits = arr.line_wdata;

  // ============================================================
  // Byte merge for store hits
  // ============================================================
  always_comb begin
    merged_bits = old_bits;
    for (int b = 0; b < `DC_BYTE_EN_BITS; b++) begin
      if (arr.byte_en[b]) begin
        merged_bits[8*b +: 8] = new_bits[8*b +: 8];
      end
    end
  end

  // Fill replaces the whole line
  assign wr_line = arr.fill ? arr.line_wdata : dcache_pkg::line_t'(merged_bits);

  dcache_sram #(
    .entry_t(dcache_pkg::line_t)
  ) line_ram (
    .clk  (clk),
    .en   (arr.lookup | arr.line_write),
    .we   (arr.line_write),
    .addr (arr.index),
    .wdata(wr_line),
    .rdata(arr.line_rdata)
  );

  // Read register holds current line data
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rd_ok <= 1'b0;
    end else if (arr.lookup) begin
      rd_ok <= 1'b1;
    end else if (arr.line_write && arr.fill) begin
      rd_ok <= 1'b0;
    end
  end

  merge_after_read_a : assert property (
    @(posedge clk) disable iff (!rstn) (arr.line_write && !arr.fill) |-> rd_ok
  ) else $error("store merge without a prior line read");

endmodule

// ==== verilog/dcache_ctrl.sv ====
// Cache FSM and Wishbone classic master; accesses are assumed aligned, one outstanding request
`include "dcache_macros.svh"

module dcache_ctrl (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          core_req,
  input  logic                          core_write,
  input  dcache_pkg::access_size_t      core_size,
  input  logic [`DC_ADDR_BITS-1:0]      core_addr,
  input  logic [`DC_WB_DATA_BITS-1:0]   core_wdata,
  output logic [`DC_WB_DATA_BITS-1:0]   core_rdata,
  output logic                          core_busy,
  output logic                          wb_cyc,
  output logic                          wb_stb,
  output logic                          wb_we,
  output logic [`DC_ADDR_BITS-1:0]      wb_adr,
  output logic [`DC_WB_DATA_BITS-1:0]   wb_dat_o,
  output logic [`DC_WB_SEL_BITS-1:0]    wb_sel,
  input  logic [`DC_WB_DATA_BITS-1:0]   wb_dat_i,
  input  logic                          wb_ack,
  output logic [`DC_STAT_BITS-1:0]      stat_hits,
  output logic [`DC_STAT_BITS-1:0]      stat_misses,
  dcache_array_if.ctrl                  arr
);

  dcache_pkg::dc_state_t             state;
  dcache_pkg::dc_state_t             state_nxt;
  logic                              req_write;
  dcache_pkg::access_size_t          req_size;
  logic [`DC_ADDR_BITS-1:0]          req_addr;
  logic [`DC_WB_DATA_BITS-1:0]       req_wdata;
  logic [`DC_ADDR_BITS-1:0]          addr_sel;
  logic [1:0]                        word_cnt;
  dcache_pkg::line_t                 fill_buf;
  dcache_pkg::line_t                 load_line;
  logic [`DC_WB_SEL_BITS-1:0]        lanes;
  logic [`DC_WB_DATA_BITS-1:0]       store_data;
  logic [`DC_WB_DATA_BITS-1:0]       load_word;
  logic [`DC_WB_DATA_BITS-1:0]       load_shift;
  logic [`DC_WB_DATA_BITS-1:0]       load_data;
  logic                              accept;
  logic                              bus_done;
  logic                              load_done;

  assign accept    = (state == dcache_pkg::ST_IDLE) && core_req;
  assign bus_done  = wb_cyc && wb_ack;
  assign core_busy = (state != dcache_pkg::ST_IDLE);

  always_ff @(posedge clk) begin
    if (accept) begin
      req_write <= core_write;
      req_size  <= core_size;
      req_addr  <= core_addr;
      req_wdata <= core_wdata;
    end
  end

  // ============================================================
  // State machine
  // ============================================================
  always_comb begin
    state_nxt = state;
    case (state)
      dcache_pkg::ST_IDLE:       if (core_req) state_nxt = dcache_pkg::ST_LOOKUP;
      dcache_pkg::ST_LOOKUP: begin
        if (req_write)    state_nxt = dcache_pkg::ST_STORE;
        else if (arr.hit) state_nxt = dcache_pkg::ST_IDLE;
        else              state_nxt = dcache_pkg::ST_READ_FILL;
      end
      dcache_pkg::ST_READ_FILL: begin
        if (bus_done && word_cnt == 2'd3) state_nxt = dcache_pkg::ST_FILL_WRITE;
      end
      dcache_pkg::ST_FILL_WRITE: state_nxt = dcache_pkg::ST_RESPOND;
      dcache_pkg::ST_RESPOND:    state_nxt = dcache_pkg::ST_IDLE;
      dcache_pkg::ST_STORE:      if (bus_done) state_nxt = dcache_pkg::ST_IDLE;
      default:                   state_nxt = dcache_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= dcache_pkg::ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Bus request drops for one cycle after every ack
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      word_cnt <= 2'd0;
    end else begin
      if (bus_done) begin
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
      end else if (state_nxt == dcache_pkg::ST_READ_FILL ||
                   state_nxt == dcache_pkg::ST_STORE) begin
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
      end
      if (state == dcache_pkg::ST_LOOKUP) begin
        word_cnt <= 2'd0;
      end else if (bus_done && state == dcache_pkg::ST_READ_FILL) begin
        word_cnt <= word_cnt + 2'd1;
      end
    end
  end

  // Line assembly in word order
  always_ff @(posedge clk) begin
    if (bus_done && state == dcache_pkg::ST_READ_FILL) begin
      fill_buf[word_cnt] <= wb_dat_i;
    end
  end

  // ============================================================
  // Byte lanes and store data
  // ============================================================
  always_comb begin
    case (req_size)
      dcache_pkg::SIZE_BYTE: begin
        lanes      = 4'b0001 << req_addr[1:0];
        store_data = {4{req_wdata[7:0]}};
      end
      dcache_pkg::SIZE_HALF: begin
        lanes      = 4'b0011 << {req_addr[1], 1'b0};
        store_data = {2{req_wdata[15:0]}};
      end
      default: begin
        lanes      = 4'b1111;
        store_data = req_wdata;
      end
    endcase
  end

  assign wb_we    = (state == dcache_pkg::ST_STORE);
  assign wb_sel   = wb_we ? lanes : {`DC_WB_SEL_BITS{1'b1}};
  assign wb_dat_o = store_data;
  assign wb_adr   = wb_we ? {req_addr[`DC_ADDR_BITS-1:`DC_WORD_LSB], 2'b00}
                          : {req_addr[`DC_ADDR_BITS-1:`DC_OFFSET_BITS], word_cnt, 2'b00};

  // Index and tag come straight from the core in the accept cycle
  assign addr_sel       = (state == dcache_pkg::ST_IDLE) ? core_addr : req_addr;
  assign arr.index      = addr_sel[`DC_TAG_LSB-1:`DC_INDEX_LSB];
  assign arr.req_tag    = addr_sel[`DC_ADDR_BITS-1:`DC_TAG_LSB];
  assign arr.lookup     = accept;
  assign arr.fill       = (state == dcache_pkg::ST_FILL_WRITE);
  assign arr.tag_write  = arr.fill;
  assign arr.line_write = arr.fill || (wb_we && bus_done && arr.hit);
  assign arr.line_wdata = arr.fill ? fill_buf : {`DC_LINE_WORDS{store_data}};
  assign arr.byte_en    = {{(`DC_BYTE_EN_BITS-`DC_WB_SEL_BITS){1'b0}}, lanes}
                          << {req_addr[`DC_OFFSET_BITS-1:`DC_WORD_LSB], 2'b00};

  // ============================================================
  // Load extraction with zero extension
  // ============================================================
  assign load_line  = (state == dcache_pkg::ST_LOOKUP) ? arr.line_rdata : fill_buf;
  assign load_word  = load_line[req_addr[`DC_OFFSET_BITS-1:`DC_WORD_LSB]];
  assign load_shift = load_word >> {req_addr[1:0], 3'b000};

  always_comb begin
    case (req_size)
      dcache_pkg::SIZE_BYTE: load_data = {24'b0, load_shift[7:0]};
      dcache_pkg::SIZE_HALF: load_data = {16'b0, load_shift[15:0]};
      default:               load_data = load_word;
    endcase
  end

  assign load_done = (state == dcache_pkg::ST_LOOKUP && !req_write && arr.hit) ||
                     (state == dcache_pkg::ST_RESPOND);

  always_ff @(posedge clk) begin
    if (load_done) begin
      core_rdata <= load_data;
    end
  end

  // Hit and miss totals over reads and writes
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stat_hits   <= '0;
      stat_misses <= '0;
    end else if (state == dcache_pkg::ST_LOOKUP) begin
      if (arr.hit) stat_hits <= stat_hits + 1'b1;
      else         stat_misses <= stat_misses + 1'b1;
    end
  end

  // Classic handshake keeps the request steady until ack
  stb_held_a : assert property (
    @(posedge clk) disable iff (!rstn)
    (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we))
  ) else $error("Wishbone request changed before ack");

  busy_on_bus_a : assert property (@(posedge clk) disable iff (!rstn) wb_cyc |-> core_busy)
    else $error("bus cycle while core side idle");

endmodule

// ==== verilog/dcache_top.sv ====
// Cache top level; core_size uses 0 byte, 1 half, 2 word and misaligned requests are not supported
`include "dcache_macros.svh"

module dcache_top (
  input  logic                        clk,
  input  logic                        rstn,
  // Core port
  input  logic                        core_req,
  input  logic                        core_write,
  input  logic [1:0]                  core_size,
  input  logic [`DC_ADDR_BITS-1:0]    core_addr,
  input  logic [`DC_WB_DATA_BITS-1:0] core_wdata,
  output logic [`DC_WB_DATA_BITS-1:0] core_rdata,
  output logic                        core_busy,
  // Wishbone master
  output logic                        wb_cyc,
  output logic                        wb_stb,
  output logic                        wb_we,
  output logic [`DC_ADDR_BITS-1:0]    wb_adr,
  output logic [`DC_WB_DATA_BITS-1:0] wb_dat_o,
  output logic [`DC_WB_SEL_BITS-1:0]  wb_sel,
  input  logic [`DC_WB_DATA_BITS-1:0] wb_dat_i,
  input  logic                        wb_ack,
  // Statistics
  output logic [`DC_STAT_BITS-1:0]    stat_hits,
  output logic [`DC_STAT_BITS-1:0]    stat_misses
);

  dcache_array_if arr ();

  dcache_ctrl ctrl_inst (
    .clk        (clk),
    .rstn       (rstn),
    .core_req   (core_req),
    .core_write (core_write),
    .core_size  (dcache_pkg::access_size_t'(core_size)),
    .core_addr  (core_addr),
    .core_wdata (core_wdata),
    .core_rdata (core_rdata),
    .core_busy  (core_busy),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_o   (wb_dat_o),
    .wb_sel     (wb_sel),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack),
    .stat_hits  (stat_hits),
    .stat_misses(stat_misses),
    .arr        (arr.ctrl)
  );

  dcache_tag_store tag_store_inst (
    .clk (clk),
    .rstn(rstn),
    .arr (arr.tag)
  );

  dcache_data_store data_store_inst (
    .clk (clk),
    .rstn(rstn),
    .arr (arr.data)
  );

endmodule

// ==== sim/tb_clock_gen.sv ====
// Free-running clock from time 0; reset is released on a falling edge after reset_cycles edges
module tb_clock_gen #(
  parameter real period_ns    = 8.0,
  parameter int  reset_cycles = 5
) (
  output logic clk,
  output logic rstn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2.0) clk = ~clk;
  end

  initial begin
    rstn = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

// ==== sim/dcache_tb.sv ====
// Run from the project root; the memory model covers byte addresses below 0x4000 only
`include "dcache_macros.svh"

module dcache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          mem_words = 4096;
  localparam logic [31:0] fill_key  = 32'hcafe_0000;

  logic        clk;
  logic        rstn;
  logic        core_req;
  logic        core_write;
  logic [1:0]  core_size;
  logic [31:0] core_addr;
  logic [31:0] core_wdata;
  logic [31:0] core_rdata;
  logic        core_busy;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_o;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_i;
  logic        wb_ack;
  logic [31:0] stat_hits;
  logic [31:0] stat_misses;

  // Case table and bus transfer log
  string       c_name[$];
  logic        c_write[$];
  logic [1:0]  c_size[$];
  logic [31:0] c_addr[$];
  logic [31:0] c_wdata[$];
  logic [31:0] c_rdata[$];
  logic        c_hit[$];
  logic [31:0] xfer_adr[$];
  logic        xfer_we[$];
  logic [3:0]  xfer_sel[$];
  logic [31:0] xfer_dat[$];
  logic [31:0] mem [mem_words];
  int          num_cases;
  int          error_count;
  int          failed_cases;
  bit          cases_loaded;

  tb_clock_gen #(.period_ns(8.0), .reset_cycles(5)) clock_gen_inst (.clk(clk), .rstn(rstn));

  dcache_top dcache_top_inst (
    .clk(clk), .rstn(rstn),
    .core_req(core_req), .core_write(core_write), .core_size(core_size),
    .core_addr(core_addr), .core_wdata(core_wdata),
    .core_rdata(core_rdata), .core_busy(core_busy),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_o(wb_dat_o), .wb_sel(wb_sel), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack),
    .stat_hits(stat_hits), .stat_misses(stat_misses)
  );

  function automatic int size_bytes(input logic [1:0] size);
    case (size)
      dcache_pkg::SIZE_BYTE: return 1;
      dcache_pkg::SIZE_HALF: return 2;
      default:               return 4;
    endcase
  endfunction

  // Lanes from the access offset up to offset plus size
  function automatic logic [3:0] byte_lanes(input logic [1:0] size, input logic [1:0] low);
    int n;
    n = size_bytes(size);
    for (int b = 0; b < 4; b++) begin
      byte_lanes[b] = (b >= low) && (b < low + n);
    end
  endfunction

  // Every lane repeats the store's bytes in order
  function automatic logic [31:0] bus_write_data(input logic [1:0] size, input logic [31:0] wd);
    int n;
    n = size_bytes(size);
    for (int b = 0; b < 4; b++) begin
      bus_write_data[8*b +: 8] = wd[8*(b % n) +: 8];
    end
  endfunction

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    $display("Mismatch in %s: %s expected %h, actual %h", name, what, exp, act);
    error_count++;
  endtask

  // ============================================================
  // Case file
  // ============================================================
  task automatic load_cases(output bit ok);
    int          fd;
    int          n;
    string       line;
    string       nm;
    string       op;
    string       sz;
    logic [31:0] ad;
    logic [31:0] wd;
    logic [31:0] rd;
    int          h;
    fd = $fopen("sim/dcache_cases.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s %s %s %h %h %h %d", nm, op, sz, ad, wd, rd, h);
          if (n == 7) begin
            c_name.push_back(nm);
            c_write.push_back(op == "wr");
            c_size.push_back(sz == "b" ? dcache_pkg::SIZE_BYTE :
                             sz == "h" ? dcache_pkg::SIZE_HALF : dcache_pkg::SIZE_WORD);
            c_addr.push_back(ad);
            c_wdata.push_back(wd);
            c_rdata.push_back(rd);
            c_hit.push_back(h != 0);
          end
        end
      end
      $fclose(fd);
    end
    num_cases = c_name.size();
  endtask

  // ============================================================
  // Wishbone memory model with 0 to 3 wait cycles per transfer
  // ============================================================
  task automatic serve_transfer();
    logic [11:0] widx;
    widx = wb_adr[13:2];
    if (wb_adr[31:14] != 0) begin
      $display("Wishbone access at %h lies outside the memory model", wb_adr);
      error_count++;
    end
    xfer_adr.push_back(wb_adr);
    xfer_we.push_back(wb_we);
    xfer_sel.push_back(wb_sel);
    xfer_dat.push_back(wb_dat_o);
    if (wb_we) begin
      for (int b = 0; b < 4; b++) begin
        if (wb_sel[b]) mem[widx][8*b +: 8] = wb_dat_o[8*b +: 8];
      end
    end else begin
      wb_dat_i = mem[widx];
    end
  endtask

  initial begin : wb_slave
    int wait_left;
    bit in_xfer;
    wait_left = 0;
    in_xfer   = 1'b0;
    forever begin
      @(negedge clk);
      if (wb_ack) begin
        wb_ack = 1'b0;
      end else if (rstn && wb_cyc && wb_stb) begin
        if (!in_xfer) begin
          in_xfer   = 1'b1;
          wait_left = $urandom % 4;
        end
        if (wait_left == 0) begin
          serve_transfer();
          wb_ack  = 1'b1;
          in_xfer = 1'b0;
        end else begin
          wait_left--;
        end
      end
    end
  end

  // ============================================================
  // One access from falling edge to falling edge
  // ============================================================
  task automatic run_case(input int idx);
    int          errs_before;
    int          busy_cycles;
    logic [31:0] hits_before;
    logic [31:0] misses_before;
    logic [31:0] base;
    string       nm;
    nm            = c_name[idx];
    errs_before   = error_count;
    hits_before   = stat_hits;
    misses_before = stat_misses;
    xfer_adr.delete();
    xfer_we.delete();
    xfer_sel.delete();
    xfer_dat.delete();
    core_req   = 1'b1;
    core_write = c_write[idx];
    core_size  = c_size[idx];
    core_addr  = c_addr[idx];
    core_wdata = c_wdata[idx];
    @(negedge clk);
    core_req = 1'b0;
    busy_cycles = 0;
    while (core_busy) begin
      busy_cycles++;
      @(negedge clk);
    end

    if (busy_cycles == 0) begin
      $display("%s: request was not accepted, core_busy never rose", nm);
      error_count++;
    end
    if (stat_hits - hits_before != 32'(c_hit[idx]))
      report_mismatch(nm, "stat_hits step", 32'(c_hit[idx]), stat_hits - hits_before);
    if (stat_misses - misses_before != 32'(!c_hit[idx]))
      report_mismatch(nm, "stat_misses step", 32'(!c_hit[idx]), stat_misses - misses_before);

    if (c_write[idx]) begin
      if (xfer_adr.size() != 1) begin
        report_mismatch(nm, "bus transfers", 1, xfer_adr.size());
      end else begin
        if (!xfer_we[0]) begin
          $display("%s: the store went out as a Wishbone read", nm);
          error_count++;
        end
        if (xfer_adr[0] != {c_addr[idx][31:2], 2'b00})
          report_mismatch(nm, "wb_adr", {c_addr[idx][31:2], 2'b00}, xfer_adr[0]);
        if (xfer_sel[0] != byte_lanes(c_size[idx], c_addr[idx][1:0]))
          report_mismatch(nm, "wb_sel", byte_lanes(c_size[idx], c_addr[idx][1:0]), xfer_sel[0]);
        if (xfer_dat[0] != bus_write_data(c_size[idx], c_wdata[idx]))
          report_mismatch(nm, "wb_dat_o", bus_write_data(c_size[idx], c_wdata[idx]), xfer_dat[0]);
      end
    end else begin
      if (core_rdata != c_rdata[idx])
        report_mismatch(nm, "core_rdata", c_rdata[idx], core_rdata);
      if (c_hit[idx]) begin
        if (xfer_adr.size() != 0)
          report_mismatch(nm, "bus transfers on a hit", 0, xfer_adr.size());
        if (busy_cycles != 1)
          report_mismatch(nm, "busy cycles on a hit", 1, busy_cycles);
      end else if (xfer_adr.size() != 4) begin
        report_mismatch(nm, "fill transfers", 4, xfer_adr.size());
      end else begin
        base = {c_addr[idx][31:4], 4'h0};
        for (int i = 0; i < 4; i++) begin
          if (xfer_we[i] || xfer_adr[i] != base + 4 * i)
            report_mismatch(nm, "fill read address", base + 4 * i, xfer_adr[i]);
          if (xfer_sel[i] != 4'hf)
            report_mismatch(nm, "fill wb_sel", 4'hf, xfer_sel[i]);
        end
      end
    end

    if (error_count == errs_before) begin
      $display("case %0d %s ok", idx, nm);
    end else begin
      $display("case %0d %s FAILED", idx, nm);
      failed_cases++;
    end
  endtask

  initial begin : main
    bit          ok;
    logic [31:0] total_hits;
    logic [31:0] total_misses;
    void'($urandom(32'h8b04));
    core_req     = 1'b0;
    core_write   = 1'b0;
    core_size    = 2'd0;
    core_addr    = '0;
    core_wdata   = '0;
    wb_dat_i     = '0;
    wb_ack       = 1'b0;
    error_count  = 0;
    failed_cases = 0;
    cases_loaded = 1'b0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = (32'(i) << 2) ^ fill_key;
    end
    load_cases(ok);
    if (!ok || num_cases == 0) begin
      $display("Case file sim/dcache_cases.txt is missing or holds no cases");
      $display("Checks failed");
      $finish;
    end else begin
      cases_loaded = 1'b1;
      wait (rstn === 1'b1);
      @(negedge clk);
      total_hits   = 0;
      total_misses = 0;
      for (int i = 0; i < num_cases; i++) begin
        run_case(i);
        if (c_hit[i]) total_hits++;
        else          total_misses++;
      end
      if (stat_hits != total_hits)
        report_mismatch("final totals", "stat_hits", total_hits, stat_hits);
      if (stat_misses != total_misses)
        report_mismatch("final totals", "stat_misses", total_misses, stat_misses);
      $display("Cases run %0d, ok %0d, with errors %0d, errors in total %0d",
               num_cases, num_cases - failed_cases, failed_cases, error_count);
      if (error_count == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

  // Watchdog allows 60 cycles per case
  initial begin : watchdog
    wait (cases_loaded);
    repeat (num_cases * 60) @(posedge clk);
    $display("Watchdog expired after %0d cycles, an access never completed", num_cases * 60);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== sim/dcache_cases.txt ====
# name op(rd/wr) size(b/h/w) addr wdata exp_rdata exp_hit(1 hit, 0 miss), values in hex
# memory word at byte address A starts as A xor cafe0000
rd_miss_a     rd w 00000104 00000000 cafe0104 0
rd_hit_word   rd w 0000010c 00000000 cafe010c 1
rd_hit_byte   rd b 00000101 00000000 00000001 1
rd_hit_half   rd h 0000010a 00000000 0000cafe 1
wr_hit_byte   wr b 00000102 000000a7 00000000 1
rd_merged_b   rd w 00000100 00000000 caa70100 1
wr_hit_half   wr h 00000106 1234beef 00000000 1
rd_merged_h   rd h 00000106 00000000 0000beef 1
rd_merged_hb  rd b 00000107 00000000 000000be 1
wr_hit_word   wr w 0000010c 0badf00d 00000000 1
rd_merged_w   rd w 0000010c 00000000 0badf00d 1
wr_miss_word  wr w 00000208 76543210 00000000 0
rd_after_wm   rd w 00000208 00000000 76543210 0
rd_near_wm    rd h 00000204 00000000 00000204 1
wr_miss_byte  wr b 00000303 0000005e 00000000 0
rd_after_bm   rd b 00000303 00000000 0000005e 0
evict_a       rd w 00000500 00000000 cafe0500 0
evict_b       rd w 00000100 00000000 caa70100 0
evict_c       rd w 00000504 00000000 cafe0504 0
evict_d       rd h 00000106 00000000 0000beef 0
evict_e       rd w 00000508 00000000 cafe0508 0
rd_miss_top   rd w 00003ffc 00000000 cafe3ffc 0
rd_hit_top    rd b 00003ff0 00000000 000000f0 1
wr_hit_top    wr h 00003ff0 0000c0de 00000000 1
rd_merged_top rd w 00003ff0 00000000 cafec0de 1

// ==== flist.f ====
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_array_if.sv
verilog/dcache_sram.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
sim/tb_clock_gen.sv
sim/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/dcache_pkg.sv
      - verilog/dcache_array_if.sv
      - verilog/dcache_sram.sv
      - verilog/dcache_tag_store.sv
      - verilog/dcache_data_store.sv
      - verilog/dcache_ctrl.sv
      - verilog/dcache_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_clock_gen.sv
      - sim/dcache_tb.sv
